/* build.f */
+incdir+logic
logic/rx_check_pkg.sv
logic/rx_word_depacker.sv
logic/frame_realign.sv
logic/pixel_fifo.sv
logic/golden_pattern_gen.sv
logic/pixel_compare.sv
logic/rx_error_clear.sv
logic/mipi_rx_checker_top.sv
test/tb_mipi_rx_checker.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the checker regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f \
   --top-module tb_mipi_rx_checker -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qx "Regression passed" sim.log; then
   echo "Simulation result: PASS"
   exit 0
else
   echo "Simulation result: FAIL"
   exit 1
fi

/* test/tb_mipi_rx_checker.sv */
// Frames run 11 lines so the FIFO never passes half full and short words only occur in the last active line
`timescale 1ns/100ps
`include "rx_check_settings.svh"

module tb_mipi_rx_checker;

   import rx_check_pkg::*;

   // **********************************************************************
   // Timing of the sent frames
   // **********************************************************************

   localparam int CLK_PERIOD   = 40;
   localparam int LINE_CYCLES  = `H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT;
   localparam int VSYNC_CYCLES = `V_SYNC * LINE_CYCLES;
   // Idle lines after vsync so the golden read trails the received data within the FIFO depth
   localparam int LEAD_CYCLES  = (`V_SYNC + `V_BACK) * LINE_CYCLES;
   localparam int FRAME_CYCLES = VSYNC_CYCLES + LEAD_CYCLES + `V_ACTIVE * LINE_CYCLES;
   localparam int NUM_WORDS    = `FRAME_PIXELS / `PIX_PER_WORD;
   // Frame end pulse lands near cycle 129 and the verdict is read a little later
   localparam int VERDICT_CYCLE = VSYNC_CYCLES + 2 * `REALIGN_DELAY + VSYNC_CYCLES + 9;
   localparam int TOTAL_FRAMES  = 15;
   localparam int WATCHDOG_CYCLES = (TOTAL_FRAMES + 2) * FRAME_CYCLES + 200;

   logic        rx_vga_clk;
   logic        rst_n;
   rx_word_t    rx_word;
   status_t     status;
   pattern_e    pattern;
   disp_pixel_t disp;
   logic        compare_pass;
   logic        rx_clear;

   // Model state
   logic [15:0] exp_disp_q [$];
   logic [15:0] exp_pix;
   bit          prev_ok;
   status_t     status_at_edge;
   int          edge_cnt;
   int          reset_edges;

   mipi_rx_checker_top mipi_rx_checker_top_i (
      .rx_vga_clk     (rx_vga_clk),
      .rst_n          (rst_n),
      .rx_word_i      (rx_word),
      .status_i       (status),
      .pattern_i      (pattern),
      .disp_o         (disp),
      .compare_pass_o (compare_pass),
      .rx_clear_o     (rx_clear)
   );

   initial begin
      rx_vga_clk = 1'b0;
      forever #(CLK_PERIOD / 2) rx_vga_clk = ~rx_vga_clk;
   end

   // **********************************************************************
   // Failure reporting and the compare task
   // **********************************************************************

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      string line;
      if (actual !== expected) begin
         line = $sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                          $time, name, actual, expected);
         stop_with_failure(line);
      end
   endtask

   // Reference pixel at active column x, row y
   function automatic logic [15:0] pattern_pixel(input pattern_e pat, input int x,
                                                 input int y);
      logic [15:0] pix;
      case (pat)
         PAT_BARS: begin
            case (x / (`H_ACTIVE / 4))
               0:       pix = 16'hf800;
               1:       pix = 16'h07e0;
               2:       pix = 16'h001f;
               default: pix = 16'hffff;
            endcase
         end
         PAT_RAMP:    pix = {5'(x), 6'(y), 5'h00};
         PAT_CHECKER: pix = ((x ^ y) & 1) ? 16'hffff : 16'h0000;
         default:     pix = 16'h8410;
      endcase
      return pix;
   endfunction

   // Any error status except the pass code
   function automatic status_t bad_status();
      status_t st;
      st = 18'($urandom);
      while (st == `STATUS_PASS) begin
         st = 18'($urandom);
      end
      return st;
   endfunction

   // **********************************************************************
   // One frame of vsync lines, lead-in lines and active lines of held words
   // **********************************************************************

   task automatic send_frame(input pattern_e pat, input int corrupt_idx,
                             input bit short_line, input status_t st);
      logic [15:0] gold [`FRAME_PIXELS];
      logic [15:0] sent [`FRAME_PIXELS];
      logic [2:0]  cnt [NUM_WORDS];
      logic [15:0] stream [$];
      logic [15:0] d;
      bit          ok;
      int          a;
      int          w;
      for (int i = 0; i < `FRAME_PIXELS; i++) begin
         gold[i] = pattern_pixel(pat, i % `H_ACTIVE, i / `H_ACTIVE);
         sent[i] = gold[i];
      end
      if (corrupt_idx >= 0) begin
         sent[corrupt_idx] = gold[corrupt_idx] ^ 16'($urandom_range(1, 16'hffff));
      end
      for (int i = 0; i < NUM_WORDS; i++) begin
         cnt[i] = 3'd4;
      end
      // One short word somewhere in the last line
      if (short_line) begin
         cnt[NUM_WORDS - 4 + $urandom_range(0, 3)] = 3'($urandom_range(1, 3));
      end
      for (int i = 0; i < NUM_WORDS; i++) begin
         for (int k = 0; k < int'(cnt[i]); k++) begin
            stream.push_back(sent[4 * i + k]);
         end
      end
      // Missing pixels read as zero from the empty FIFO at line end
      ok = 1'b1;
      for (int i = 0; i < `FRAME_PIXELS; i++) begin
         d = (i < stream.size()) ? stream[i] : 16'h0000;
         if (d != gold[i]) ok = 1'b0;
         exp_disp_q.push_back(d);
      end
      for (int c = 0; c < FRAME_CYCLES; c++) begin
         @(posedge rx_vga_clk);
         #2;
         if (c == 0) status = st;
         // Previous frame is fully read by now
         if (c == VSYNC_CYCLES) pattern = pat;
         rx_word = '0;
         rx_word.vsync = (c < VSYNC_CYCLES);
         a = c - VSYNC_CYCLES - LEAD_CYCLES;
         if (a >= 0 && (a % LINE_CYCLES) < `H_ACTIVE) begin
            w = (a / LINE_CYCLES) * 4 + (a % LINE_CYCLES) / 4;
            rx_word.valid = 1'b1;
            rx_word.count = cnt[w];
            rx_word.data  = {sent[4 * w], sent[4 * w + 1], sent[4 * w + 2], sent[4 * w + 3]};
         end
         // Verdict of the frame before this one
         if (c == VERDICT_CYCLE) begin
            @(negedge rx_vga_clk);
            check_value("compare_pass_o", compare_pass, prev_ok && (st == `STATUS_PASS));
         end
      end
      prev_ok = ok;
   endtask

   // **********************************************************************
   // Monitors for display order and error clear
   // **********************************************************************

   // Status and reset as the DUT samples them
   always @(posedge rx_vga_clk) begin
      status_at_edge <= status;
      if (rst_n) edge_cnt <= edge_cnt + 1;
      else reset_edges <= reset_edges + 1;
   end

   always @(negedge rx_vga_clk) begin
      if (edge_cnt == 0 && reset_edges > 0) begin
         check_value("rx_clear_o", rx_clear, 1);
         check_value("compare_pass_o", compare_pass, 0);
         check_value("disp_o.active", disp.active, 0);
      end
      if (edge_cnt > 0) begin
         // Clear only on interval wraps with a failing status
         check_value("rx_clear_o", rx_clear,
                     (edge_cnt % `CLEAR_INTERVAL == 0) &&
                     (status_at_edge != `STATUS_PASS));
         if (disp.active) begin
            if (exp_disp_q.size() == 0) begin
               stop_with_failure("Active display pixel seen with no pixel expected");
            end else begin
               exp_pix = exp_disp_q.pop_front();
               check_value("disp_o.pix", disp.pix, exp_pix);
            end
         end else begin
            check_value("disp_o.pix", disp.pix, 0);
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      stop_with_failure("Timeout, the stimulus did not finish in the expected time");
   end

   // **********************************************************************
   // Test sequence
   // **********************************************************************

   initial begin
      pattern_e pat;
      void'($urandom(32'h867d_8026));
      rst_n       = 1'b0;
      rx_word     = '0;
      status      = `STATUS_PASS;
      pattern     = PAT_BARS;
      prev_ok     = 1'b0;
      edge_cnt    = 0;
      reset_edges = 0;
      pat         = PAT_BARS;
      repeat (2) @(posedge rx_vga_clk);
      #2;
      rst_n = 1'b1;

      // Clean frames on two random patterns
      for (int t = 0; t < 2; t++) begin
         pat = pattern_e'(2'($urandom_range(0, 3)));
         repeat (3) send_frame(pat, -1, 1'b0, `STATUS_PASS);
      end

      // Single corrupted pixel then recovery
      send_frame(pat, $urandom_range(0, `FRAME_PIXELS - 1), 1'b0, `STATUS_PASS);
      repeat (2) send_frame(pat, -1, 1'b0, `STATUS_PASS);

      // Receiver reports errors
      repeat (2) send_frame(pat, -1, 1'b0, bad_status());
      send_frame(pat, -1, 1'b0, `STATUS_PASS);

      // Short words in the last line
      send_frame(pat, -1, 1'b1, `STATUS_PASS);
      repeat (2) send_frame(pat, -1, 1'b0, `STATUS_PASS);

      // Let the last frame drain with vsync held high
      @(posedge rx_vga_clk);
      #2;
      rx_word       = '0;
      rx_word.vsync = 1'b1;
      repeat (LINE_CYCLES) @(posedge rx_vga_clk);
      @(negedge rx_vga_clk);
      if (exp_disp_q.size() != 0) begin
         stop_with_failure("Some sent pixels never reached the display output");
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

/* logic/mipi_rx_checker_top.sv */
// Single clock domain and the receive word has no handshake so FIFO overruns appear as failures
`timescale 1ns/100ps
`include "rx_check_settings.svh"

module mipi_rx_checker_top (
   input  logic                      rx_vga_clk,
   input  logic                      rst_n,
   input  rx_check_pkg::rx_word_t    rx_word_i,
   input  rx_check_pkg::status_t     status_i,
   input  rx_check_pkg::pattern_e    pattern_i,
   output rx_check_pkg::disp_pixel_t disp_o,
   output logic                      compare_pass_o,
   output logic                      rx_clear_o
);

   import rx_check_pkg::*;

   rgb565_t     rx_pix;
   logic        rx_pix_we;
   logic        rx_realign;
   logic        golden_realign;
   logic        golden_vsync;
   logic        golden_rd_en;
   disp_pixel_t golden;
   rgb565_t     fifo_dout;

   // **********************************************************************
   // Receive path, word to pixels to FIFO
   // **********************************************************************

   rx_word_depacker rx_word_depacker_i (
      .rx_vga_clk (rx_vga_clk),
      .rst_n      (rst_n),
      .word_i     (rx_word_i),
      .pix_o      (rx_pix),
      .pix_we_o   (rx_pix_we)
   );

   // Flush status flags are internal to the FIFO
   pixel_fifo #(.ADDR_W(`FIFO_ADDR_W)) pixel_fifo_i (
      .rx_vga_clk (rx_vga_clk),
      .rst_n      (rst_n),
      .flush_i    (rx_realign),
      .we_i       (rx_pix_we),
      .din_i      (rx_pix),
      .re_i       (golden_rd_en),
      .dout_o     (fifo_dout),
      .empty_o    (),
      .full_o     ()
   );

   // Frame alignment from both vsyncs
   frame_realign frame_realign_i (
      .rx_vga_clk       (rx_vga_clk),
      .rst_n            (rst_n),
      .rx_vsync_i       (rx_word_i.vsync),
      .golden_vsync_i   (golden_vsync),
      .rx_realign_o     (rx_realign),
      .golden_realign_o (golden_realign)
   );

   // **********************************************************************
   // Golden raster, comparison and error clear
   // **********************************************************************

   golden_pattern_gen golden_pattern_gen_i (
      .rx_vga_clk (rx_vga_clk),
      .rst_n      (rst_n),
      .restart_i  (rx_realign),
      .pattern_i  (pattern_i),
      .vsync_o    (golden_vsync),
      .rd_en_o    (golden_rd_en),
      .golden_o   (golden)
   );

   pixel_compare pixel_compare_i (
      .rx_vga_clk  (rx_vga_clk),
      .rst_n       (rst_n),
      .golden_i    (golden),
      .rx_pix_i    (fifo_dout),
      .frame_end_i (golden_realign),
      .status_i    (status_i),
      .pass_o      (compare_pass_o)
   );

   rx_error_clear rx_error_clear_i (
      .rx_vga_clk (rx_vga_clk),
      .rst_n      (rst_n),
      .status_i   (status_i),
      .clear_o    (rx_clear_o)
   );

   // Display pixel is blanked outside the golden active area
   assign disp_o = '{pix: golden.active ? fifo_dout : '0, active: golden.active};

endmodule

/* logic/rx_error_clear.sv */
// Clear is issued only on interval boundaries so a new error can wait up to CLEAR_INTERVAL cycles
`timescale 1ns/100ps
`include "rx_check_settings.svh"

module rx_error_clear (
   input  logic                  rx_vga_clk,
   input  logic                  rst_n,
   input  rx_check_pkg::status_t status_i,
   output logic                  clear_o
);

   localparam int CNT_W = $clog2(`CLEAR_INTERVAL + 1);

   logic [CNT_W-1:0] cnt_q;

   // Interval counter runs 1 to CLEAR_INTERVAL
   // first check lands one full interval after reset
   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         cnt_q   <= CNT_W'(1);
         clear_o <= 1'b1;
      end else if (cnt_q == CNT_W'(`CLEAR_INTERVAL)) begin
         cnt_q   <= CNT_W'(1);
         // Pulse only while the receiver still reports an error
         clear_o <= (status_i != `STATUS_PASS);
      end else begin
         cnt_q   <= cnt_q + 1'b1;
         clear_o <= 1'b0;
      end
   end

endmodule

/* logic/pixel_compare.sv */
// Pass needs one full frame of consecutive matches and a clean receiver status at the same time
`timescale 1ns/100ps
`include "rx_check_settings.svh"

module pixel_compare (
   input  logic                      rx_vga_clk,
   input  logic                      rst_n,
   input  rx_check_pkg::disp_pixel_t golden_i,
   input  rx_check_pkg::rgb565_t     rx_pix_i,
   input  logic                      frame_end_i,
   input  rx_check_pkg::status_t     status_i,
   output logic                      pass_o
);

   // One spare bit above the frame size
   localparam int CNT_W = $clog2(`FRAME_PIXELS + 1) + 1;

   logic [CNT_W-1:0] run_q;
   logic [CNT_W-1:0] max_q;
   logic             match;

   assign match = (rx_pix_i == golden_i.pix);

   // **********************************************************************
   // Run-length counter and per-frame latch
   // **********************************************************************

   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         run_q <= '0;
         max_q <= '0;
      end else if (frame_end_i) begin
         // Close the frame, keep the run for the verdict
         max_q <= run_q;
         run_q <= '0;
      end else if (golden_i.active) begin
         // Any mismatch restarts the run
         if (match) begin
            run_q <= run_q + 1'b1;
         end else begin
            run_q <= '0;
         end
      end
   end

   // Verdict follows the latched maximum
   // status is checked live as in the receiver
   assign pass_o = (max_q == CNT_W'(`FRAME_PIXELS)) && (status_i == `STATUS_PASS);

endmodule

/* logic/golden_pattern_gen.sv */
// Pattern select is sampled every cycle so changing it mid-frame corrupts that frame
`timescale 1ns/100ps
`include "rx_check_settings.svh"

module golden_pattern_gen (
   input  logic                      rx_vga_clk,
   input  logic                      rst_n,
   input  logic                      restart_i,
   input  rx_check_pkg::pattern_e    pattern_i,
   output logic                      vsync_o,
   output logic                      rd_en_o,
   output rx_check_pkg::disp_pixel_t golden_o
);

   import rx_check_pkg::*;

   localparam int H_TOTAL = `H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT;
   localparam int V_TOTAL = `V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT;
   localparam int H_START = `H_SYNC + `H_BACK;
   localparam int V_START = `V_SYNC + `V_BACK;
   localparam int H_W     = $clog2(H_TOTAL);
   localparam int V_W     = $clog2(V_TOTAL);

   // Colour constants for the reference patterns
   localparam rgb565_t RED   = '{r: 5'h1f, g: 6'h00, b: 5'h00};
   localparam rgb565_t GREEN = '{r: 5'h00, g: 6'h3f, b: 5'h00};
   localparam rgb565_t BLUE  = '{r: 5'h00, g: 6'h00, b: 5'h1f};
   localparam rgb565_t WHITE = '{r: 5'h1f, g: 6'h3f, b: 5'h1f};
   localparam rgb565_t BLACK = '{r: 5'h00, g: 6'h00, b: 5'h00};
   localparam rgb565_t GRAY  = '{r: 5'h10, g: 6'h20, b: 5'h10};

   logic [H_W-1:0] h_q;
   logic [V_W-1:0] v_q;
   logic [H_W-1:0] x;
   logic [V_W-1:0] y;
   logic [1:0]     quarter;
   logic           h_act;
   logic           v_act;
   rgb565_t        pat_pix;
   rgb565_t        pix_q;
   logic           act_q;

   // **********************************************************************
   // Raster counters, count 0 is the first sync cycle
   // **********************************************************************

   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n || restart_i) begin
         h_q <= '0;
         v_q <= '0;
      end else if (h_q == H_W'(H_TOTAL - 1)) begin
         h_q <= '0;
         v_q <= (v_q == V_W'(V_TOTAL - 1)) ? '0 : v_q + 1'b1;
      end else begin
         h_q <= h_q + 1'b1;
      end
   end

   assign h_act   = (h_q >= H_W'(H_START)) && (h_q < H_W'(H_START + `H_ACTIVE));
   assign v_act   = (v_q >= V_W'(V_START)) && (v_q < V_W'(V_START + `V_ACTIVE));
   assign vsync_o = (v_q < V_W'(`V_SYNC));
   assign rd_en_o = h_act && v_act;

   // Position inside the active area
   assign x       = h_q - H_W'(H_START);
   assign y       = v_q - V_W'(V_START);
   assign quarter = 2'(x / H_W'(`H_ACTIVE / 4));

   // **********************************************************************
   // Reference patterns
   // **********************************************************************

   always_comb begin
      case (pattern_i)
         PAT_BARS: begin
            case (quarter)
               2'd0:    pat_pix = RED;
               2'd1:    pat_pix = GREEN;
               2'd2:    pat_pix = BLUE;
               default: pat_pix = WHITE;
            endcase
         end
         PAT_RAMP:    pat_pix = '{r: 5'(x), g: 6'(y), b: 5'h00};
         PAT_CHECKER: pat_pix = (x[0] ^ y[0]) ? WHITE : BLACK;
         default:     pat_pix = GRAY;
      endcase
   end

   // Registered so it lines up with FIFO read data
   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) act_q <= 1'b0;
      else act_q <= rd_en_o;
   end

   always_ff @(posedge rx_vga_clk) begin
      pix_q <= rd_en_o ? pat_pix : BLACK;
   end

   assign golden_o = '{pix: pix_q, active: act_q};

endmodule

/* logic/pixel_fifo.sv */
// Writes into a full FIFO are dropped and reads from an empty FIFO return zero
`timescale 1ns/100ps

module pixel_fifo #(
   parameter int ADDR_W = 5
) (
   input  logic                  rx_vga_clk,
   input  logic                  rst_n,
   input  logic                  flush_i,
   input  logic                  we_i,
   input  rx_check_pkg::rgb565_t din_i,
   input  logic                  re_i,
   output rx_check_pkg::rgb565_t dout_o,
   output logic                  empty_o,
   output logic                  full_o
);

   import rx_check_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;

   rgb565_t           mem [DEPTH];
   logic [ADDR_W-1:0] wr_ptr_q;
   logic [ADDR_W-1:0] rd_ptr_q;
   logic [ADDR_W:0]   count_q;
   logic              do_wr;
   logic              do_rd;

   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == (ADDR_W+1)'(DEPTH));
   assign do_wr   = we_i && !full_o;
   assign do_rd   = re_i && !empty_o;

   // Pointers and occupancy, flush behaves like a reset
   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n || flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_rd) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Storage and read data, valid the cycle after re_i
   always_ff @(posedge rx_vga_clk) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= din_i;
      end
      if (re_i) begin
         dout_o <= do_rd ? mem[rd_ptr_q] : '0;
      end
   end

endmodule

/* logic/frame_realign.sv */
// Vsync inputs are single-clock levels and REALIGN_DELAY must be at least 2
`timescale 1ns/100ps
`include "rx_check_settings.svh"

module frame_realign (
   input  logic rx_vga_clk,
   input  logic rst_n,
   input  logic rx_vsync_i,
   input  logic golden_vsync_i,
   output logic rx_realign_o,
   output logic golden_realign_o
);

   localparam int DLY = `REALIGN_DELAY;

   // Index 0 is the receive vsync, index 1 the golden vsync
   // top bit of each line keeps the previous tap for the edge detect
   logic [1:0][DLY:0] dly_q;
   logic [1:0]        vs_in;
   logic [1:0]        fall;

   assign vs_in = {golden_vsync_i, rx_vsync_i};

   // **********************************************************************
   // Delay lines
   // **********************************************************************

   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         dly_q <= '0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            dly_q[i] <= {dly_q[i][DLY-1:0], vs_in[i]};
         end
      end
   end

   // Falling edge seen at the end of each line
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         fall[i] = dly_q[i][DLY] & ~dly_q[i][DLY-1];
      end
   end

   assign rx_realign_o     = fall[0];   // flushes FIFO, restarts golden raster
   assign golden_realign_o = fall[1];   // closes the comparison frame

endmodule

/* logic/rx_word_depacker.sv */
// Each receive word must stay held for four cycles while valid is high and pixels cannot be stalled
`timescale 1ns/100ps
`include "rx_check_settings.svh"

module rx_word_depacker (
   input  logic                   rx_vga_clk,
   input  logic                   rst_n,
   input  rx_check_pkg::rx_word_t word_i,
   output rx_check_pkg::rgb565_t  pix_o,
   output logic                   pix_we_o
);

   localparam int SLOT_W = $clog2(`PIX_PER_WORD);

   // Slot within the held word, 0 is the first pixel
   logic [SLOT_W-1:0] slot_q;
   logic              slot_hit;
   int unsigned       field_lsb;

   // Slot 0 maps to bits 63:48, later slots walk down
   always_comb begin
      field_lsb = (`PIX_PER_WORD - 1 - int'(slot_q)) * 16;
   end

   // Slots at or above count carry no pixel
   assign slot_hit = word_i.valid && ({1'b0, slot_q} < word_i.count);

   // Slot counter
   // restarts whenever valid drops so the next word begins at slot 0
   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         slot_q <= '0;
      end else if (!word_i.valid) begin
         slot_q <= '0;
      end else if (slot_q == SLOT_W'(`PIX_PER_WORD - 1)) begin
         slot_q <= '0;
      end else begin
         slot_q <= slot_q + 1'b1;
      end
   end

   // Write strobe, one per emitted pixel
   always_ff @(posedge rx_vga_clk) begin
      if (!rst_n) begin
         pix_we_o <= 1'b0;
      end else begin
         pix_we_o <= slot_hit;
      end
   end

   // Pixel payload, only meaningful with the strobe
   always_ff @(posedge rx_vga_clk) begin
      if (slot_hit) begin
         pix_o <= word_i.data[field_lsb +: 16];
      end
   end

endmodule

/* logic/rx_check_pkg.sv */
// Shared types only, field widths are fixed by the RGB565 receive format
package rx_check_pkg;

   // **********************************************************************
   // Pixel and word formats
   // **********************************************************************

   // One RGB565 pixel, red in the top bits
   typedef struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
   } rgb565_t;

   // Held receive word as seen from the receiver core
   // first pixel sits in data[63:48]
   typedef struct packed {
      logic [63:0] data;
      logic        valid;
      // Number of pixels in this word, 1 to 4
      logic [2:0]  count;
      // Level, falling edge starts a frame
      logic        vsync;
   } rx_word_t;

   // Display pixel with its active flag
   typedef struct packed {
      rgb565_t pix;
      logic    active;
   } disp_pixel_t;

   // **********************************************************************
   // Pattern select and status
   // **********************************************************************

   typedef enum logic [1:0] {
      PAT_BARS,
      PAT_RAMP,
      PAT_CHECKER,
      PAT_SOLID
   } pattern_e;

   // Raw receiver error status, 18'h200 means clean
   typedef logic [17:0] status_t;

endpackage

/* logic/rx_check_settings.svh */
// Raster and FIFO sizes are shrunk for simulation and the FIFO must hold REALIGN_DELAY pixels
`ifndef RX_CHECK_SETTINGS_SVH
`define RX_CHECK_SETTINGS_SVH

// **********************************************************************
// Golden raster timing in rx_vga_clk cycles
// **********************************************************************

// Horizontal, line total 24
`define H_SYNC   4
`define H_BACK   2
`define H_ACTIVE 16
`define H_FRONT  2

// Vertical, frame total 10 lines
`define V_SYNC   2
`define V_BACK   1
`define V_ACTIVE 6
`define V_FRONT  1

// Receive FIFO is 32 deep, realign waits half of that
`define FIFO_ADDR_W   5
`define REALIGN_DELAY 16

// RGB565 pixels packed in one 64-bit receive word
`define PIX_PER_WORD 4

// Receiver error status code meaning no error
`define STATUS_PASS    18'h200
`define CLEAR_INTERVAL 15
`define FRAME_PIXELS   96

`endif
